// File: fc_layer.f
+incdir+source
source/fc_layer_pkg.sv
source/fc_sequencer.sv
source/dot_product8.sv
source/psum_accumulator.sv
source/relu_quantizer.sv
source/fc_layer_top.sv
tb/tb_clock_gen.sv
tb/sram_model.sv
tb/fc_layer_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -Wno-fatal
TOP       := fc_layer_tb
FILELIST  := fc_layer.f
OBJ_DIR   := obj_dir
PASS_MSG  := STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb/fc_layer_tb.sv
`include "fc_layer_defines.svh"

module fc_layer_tb
    import fc_layer_pkg::*;
();

    localparam int in_words = `FC_IN_LEN / 4;
    localparam int w_words = `FC_OUT_CH * in_words;
    localparam int out_words = `FC_OUT_CH / 4;
    localparam int run_timeout = 2 * `FC_OUT_CH * (`FC_IN_LEN / 8 + `FC_RD_LAT + 8);
    localparam int n_rows = 7;

    typedef struct packed {
        logic [31:0] scale;
        logic        rand_fill;
        logic [7:0]  w_byte;
        logic [7:0]  a_byte;
        logic [7:0]  want_byte;
    } test_row_t;

    // scale, random fill, weight byte, activation byte, expected output
    localparam test_row_t rows [n_rows] = '{
        '{32'd1000, 1'b0, 8'h02, 8'h03, 8'd36},
        '{32'd5000, 1'b0, 8'hfd, 8'h05, 8'd0},
        '{32'd65536, 1'b0, 8'h64, 8'h64, 8'd127},
        '{32'd40, 1'b1, 8'h00, 8'h00, 8'd0},
        '{32'd20000, 1'b0, 8'h01, 8'h01, 8'd122},
        '{32'd21000, 1'b0, 8'hff, 8'hff, 8'd127},
        '{32'd8, 1'b1, 8'h00, 8'h00, 8'd0}
    };

    logic                  clk;
    logic                  rst_n;
    logic                  start;
    logic                  finish;
    logic [31:0]           scale;
    rd_req_t               weight_rd;
    rd_req_t               act_rd;
    word_pair_t            weight_rdata;
    word_pair_t            act_rdata;
    act_wr_t               act_wr;
    logic                  w_load;
    logic                  a_load;
    logic [`FC_ADDR_W-1:0] load_addr;
    logic [31:0]           load_data;
    logic [31:0]           w_mem [w_words];
    logic [31:0]           a_mem [in_words];
    logic                  timed_out;
    int                    err_value;
    int                    err_mon = 0;
    int                    finish_cycles = 0;
    int                    finish_rises = 0;
    int                    write_seq = 0;
    int                    wr_ch;
    logic                  finish_q = 1'b0;

    tb_clock_gen i_tb_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    sram_model #(.LAT(`FC_RD_LAT)) i_weight_sram (
        .clk       (clk),
        .rd        (weight_rd),
        .rdata     (weight_rdata),
        .wr        (act_wr_t'('0)),
        .load_en   (w_load),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    sram_model #(.LAT(`FC_RD_LAT)) i_act_sram (
        .clk       (clk),
        .rd        (act_rd),
        .rdata     (act_rdata),
        .wr        (act_wr),
        .load_en   (a_load),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    fc_layer_top i_fc_layer_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .finish       (finish),
        .scale        (scale),
        .weight_rd    (weight_rd),
        .weight_rdata (weight_rdata),
        .act_rd       (act_rd),
        .act_rdata    (act_rdata),
        .act_wr       (act_wr)
    );

    // channels are written in order, so the write count gives the channel
    always @(negedge clk) begin
        if (rst_n) begin
            finish_q <= finish;
            if (finish) begin
                finish_cycles <= finish_cycles + 1;
            end
            if (finish && !finish_q) begin
                finish_rises <= finish_rises + 1;
            end
            if (act_wr.we != 4'b0000) begin
                wr_ch = write_seq % `FC_OUT_CH;
                if (act_wr.we != 4'(4'b0001 << (wr_ch % 4))
                        || act_wr.addr != `FC_ADDR_W'(`FC_ACT_OUT_BASE + wr_ch / 4)) begin
                    $display("[FAIL] %0t: write to word %0d with enables %b, expected channel %0d",
                             $time, act_wr.addr, act_wr.we, wr_ch);
                    err_mon <= err_mon + 1;
                end
                write_seq <= write_seq + 1;
            end
        end
    end

    function automatic logic [7:0] model_byte(input logic [31:0] row_scale, input int ch);
        longint            sum;
        longint            scaled;
        logic signed [7:0] wb;
        logic signed [7:0] ab;
        sum = 0;
        for (int i = 0; i < `FC_IN_LEN; i++) begin
            wb = w_mem[ch * in_words + i / 4][8*(i%4) +: 8];
            ab = a_mem[i / 4][8*(i%4) +: 8];
            sum += longint'(wb) * longint'(ab);
        end
        if (sum < 0) begin
            sum = 0;
        end
        scaled = (sum * longint'(row_scale)) >>> `FC_QUANT_SHIFT;
        return (scaled > 127) ? 8'd127 : scaled[7:0];
    endfunction

    task automatic load_word(input logic to_act, input logic [`FC_ADDR_W-1:0] addr,
                             input logic [31:0] data);
        w_load = !to_act;
        a_load = to_act;
        load_addr = addr;
        load_data = data;
        @(posedge clk);
        #1;
        w_load = 1'b0;
        a_load = 1'b0;
    endtask

    task automatic fill_memories(input test_row_t row);
        logic [`FC_ADDR_W-1:0] addr;
        for (int k = 0; k < w_words; k++) begin
            w_mem[k] = row.rand_fill ? $urandom : {4{row.w_byte}};
            load_word(1'b0, `FC_ADDR_W'(`FC_WEIGHT_BASE + k), w_mem[k]);
        end
        for (int k = 0; k < in_words; k++) begin
            a_mem[k] = row.rand_fill ? $urandom : {4{row.a_byte}};
            load_word(1'b1, `FC_ADDR_W'(`FC_ACT_IN_BASE + k), a_mem[k]);
        end
        // bit 7 set in every byte marks an unwritten result
        for (int k = 0; k < out_words; k++) begin
            addr = `FC_ADDR_W'(`FC_ACT_OUT_BASE + k);
            load_word(1'b1, addr, {1'b1, addr[15:9], 1'b1, addr[8:2], 1'b1, addr[1:0], 5'h15, 8'hff});
        end
    endtask

    task automatic check_idle();
        repeat (20) begin
            @(negedge clk);
            if (weight_rd != '0 || act_rd != '0 || act_wr.we != 4'b0000 || finish) begin
                $display("[FAIL] %0t: engine active before start", $time);
                err_value++;
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic run_row(input int r);
        test_row_t  row;
        int         cycles;
        logic [7:0] got;
        logic [7:0] want;
        row = rows[r];
        fill_memories(row);
        scale = row.scale;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        cycles = 0;
        while (!finish && cycles < run_timeout) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!finish) begin
            $display("Row %0d never finished within %0d cycles.", r, run_timeout);
            timed_out = 1'b1;
            return;
        end
        repeat (4) @(posedge clk);
        #1;
        for (int ch = 0; ch < `FC_OUT_CH; ch++) begin
            got = i_act_sram.mem[`FC_ACT_OUT_BASE + ch / 4][8*(ch%4) +: 8];
            want = row.rand_fill ? model_byte(row.scale, ch) : row.want_byte;
            if (got !== want) begin
                $display("[FAIL] %0t: row %0d channel %0d gave %0d, expected %0d",
                         $time, r, ch, got, want);
                err_value++;
            end
        end
        for (int k = 0; k < in_words; k++) begin
            if (i_act_sram.mem[`FC_ACT_IN_BASE + k] !== a_mem[k]) begin
                $display("[FAIL] %0t: row %0d input word %0d overwritten", $time, r, k);
                err_value++;
            end
        end
        if (finish_cycles != r + 1 || finish_rises != r + 1
                || write_seq != (r + 1) * `FC_OUT_CH) begin
            $display("[FAIL] %0t: after row %0d finish high %0d cycles in %0d pulses, %0d writes",
                     $time, r, finish_cycles, finish_rises, write_seq);
            err_value++;
        end
    endtask

    initial begin
        int cycles;
        start = 1'b0;
        scale = '0;
        w_load = 1'b0;
        a_load = 1'b0;
        load_addr = '0;
        load_data = '0;
        timed_out = 1'b0;
        err_value = 0;
        void'($urandom(32'h0ec6_2a99));
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < 100) begin
            @(posedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("Reset was never released.");
            timed_out = 1'b1;
        end else begin
            #1;
            check_idle();
            for (int r = 0; r < n_rows && !timed_out; r++) begin
                run_row(r);
            end
        end
        $display("errors: %0d value, %0d write, %0d timeout", err_value, err_mon, timed_out);
        if (err_value == 0 && err_mon == 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: tb/sram_model.sv
`include "fc_layer_defines.svh"

module sram_model
    import fc_layer_pkg::*;
#(
    parameter int LAT = 1
) (
    input  logic                  clk,
    input  rd_req_t               rd,
    output word_pair_t            rdata,
    input  act_wr_t               wr,
    input  logic                  load_en,
    input  logic [`FC_ADDR_W-1:0] load_addr,
    input  logic [31:0]           load_data
);

    logic [31:0] mem [0:(1 << `FC_ADDR_W)-1];
    word_pair_t  rd_pipe [LAT];

    always_ff @(posedge clk) begin
        // word at addr0 lands in the low half
        rd_pipe[0] <= rd.en ? {mem[rd.addr1], mem[rd.addr0]} : '0;
        for (int i = 1; i < LAT; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
        for (int b = 0; b < 4; b++) begin
            if (wr.we[b]) begin
                mem[wr.addr][8*b +: 8] <= wr.data[8*b +: 8];
            end
        end
    end

    assign rdata = rd_pipe[LAT-1];

endmodule

// File: tb/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int HALF_PERIOD = 4,
    parameter int RST_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release reset just after an edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// File: source/fc_layer_top.sv
`include "fc_layer_defines.svh"

module fc_layer_top
    import fc_layer_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    output logic        finish,
    input  logic [31:0] scale,
    output rd_req_t     weight_rd,
    input  word_pair_t  weight_rdata,
    output rd_req_t     act_rd,
    input  word_pair_t  act_rdata,
    output act_wr_t     act_wr
);

    mac_tag_t               rd_tag;
    mac_tag_t               mac_tag;
    psum_t                  product;
    psum_t                  psum;
    logic [`FC_CH_BITS-1:0] sum_channel;
    logic                   sum_valid;

    fc_sequencer i_fc_sequencer (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .act_wr    (act_wr),
        .weight_rd (weight_rd),
        .act_rd    (act_rd),
        .tag       (rd_tag),
        .finish    (finish)
    );

    dot_product8 i_dot_product8 (
        .clk     (clk),
        .rst_n   (rst_n),
        .weights (weight_rdata),
        .acts    (act_rdata),
        .tag_in  (rd_tag),
        .product (product),
        .tag_out (mac_tag)
    );

    psum_accumulator i_psum_accumulator (
        .clk       (clk),
        .rst_n     (rst_n),
        .product   (product),
        .tag       (mac_tag),
        .psum      (psum),
        .channel   (sum_channel),
        .sum_valid (sum_valid)
    );

    relu_quantizer i_relu_quantizer (
        .clk       (clk),
        .rst_n     (rst_n),
        .scale     (scale),
        .psum      (psum),
        .channel   (sum_channel),
        .sum_valid (sum_valid),
        .act_wr    (act_wr)
    );

endmodule

// File: source/relu_quantizer.sv
`include "fc_layer_defines.svh"

module relu_quantizer
    import fc_layer_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [31:0]            scale,
    input  psum_t                  psum,
    input  logic [`FC_CH_BITS-1:0] channel,
    input  logic                   sum_valid,
    output act_wr_t                act_wr
);

    localparam int sat_lsb = `FC_QUANT_SHIFT + 7;
    localparam logic [`FC_ADDR_W-1:0] out_base = `FC_ADDR_W'(`FC_ACT_OUT_BASE);

    psum_t              relu;
    logic signed [63:0] scaled;
    logic [7:0]         q_byte;
    logic [1:0]         lane;

    assign relu = psum[31] ? '0 : psum;
    assign scaled = relu * $signed(scale);

    // anything at or above bit 7 of the result saturates
    assign q_byte = (scaled[63:sat_lsb] == '0) ? scaled[`FC_QUANT_SHIFT +: 8] : 8'd127;

    // four channels share one output word
    assign lane = channel[1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            act_wr <= '0;
        end else begin
            act_wr.we <= 4'b0000;
            if (sum_valid) begin
                act_wr.we <= 4'b0001 << lane;
                act_wr.addr <= out_base + `FC_ADDR_W'(channel[`FC_CH_BITS-1:2]);
                act_wr.data <= {24'd0, q_byte} << {lane, 3'b000};
            end
        end
    end

endmodule

// File: source/psum_accumulator.sv
`include "fc_layer_defines.svh"

module psum_accumulator
    import fc_layer_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  psum_t                  product,
    input  mac_tag_t               tag,
    output psum_t                  psum,
    output logic [`FC_CH_BITS-1:0] channel,
    output logic                   sum_valid
);

    logic first;

    // running sum, restarted on a channel's first beat
    always_ff @(posedge clk) begin
        if (tag.valid) begin
            psum <= first ? product : psum + product;
        end
        if (tag.valid && tag.last) begin
            channel <= tag.channel;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            first <= 1'b1;
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= tag.valid && tag.last;
            if (tag.valid) begin
                first <= tag.last;
            end
        end
    end

endmodule

// File: source/dot_product8.sv
module dot_product8
    import fc_layer_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  word_pair_t weights,
    input  word_pair_t acts,
    input  mac_tag_t   tag_in,
    output psum_t      product,
    output mac_tag_t   tag_out
);

    psum_t lane_sum;

    // eight signed int8 lanes
    always_comb begin
        logic signed [15:0] lane_prod;
        lane_sum = '0;
        for (int i = 0; i < 8; i++) begin
            lane_prod = $signed(weights[i]) * $signed(acts[i]);
            lane_sum = lane_sum + psum_t'(lane_prod);
        end
    end

    // idle cycles add nothing
    always_ff @(posedge clk) begin
        product <= tag_in.valid ? lane_sum : '0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tag_out <= '0;
        end else begin
            tag_out <= tag_in;
        end
    end

endmodule

// File: source/fc_sequencer.sv
`include "fc_layer_defines.svh"

module fc_sequencer
    import fc_layer_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     start,
    input  act_wr_t  act_wr,
    output rd_req_t  weight_rd,
    output rd_req_t  act_rd,
    output mac_tag_t tag,
    output logic     finish
);

    localparam logic [`FC_ADDR_W-1:0] words_per_ch = `FC_ADDR_W'(`FC_IN_LEN / 4);
    localparam logic [`FC_ADDR_W-1:0] last_word = `FC_ADDR_W'(`FC_IN_LEN / 4 - 2);
    localparam logic [`FC_ADDR_W-1:0] weight_base = `FC_ADDR_W'(`FC_WEIGHT_BASE);
    localparam logic [`FC_ADDR_W-1:0] act_in_base = `FC_ADDR_W'(`FC_ACT_IN_BASE);
    localparam logic [`FC_CH_BITS-1:0] last_ch = `FC_CH_BITS'(`FC_OUT_CH - 1);

    typedef enum logic [1:0] {
        s_idle,
        s_issue,
        s_drain,
        s_done
    } state_t;

    state_t                 state;
    logic [`FC_CH_BITS-1:0] ch_cnt;
    logic [`FC_ADDR_W-1:0]  ch_base;
    logic [`FC_ADDR_W-1:0]  word_cnt;
    logic                   issue;
    logic                   last_beat;
    mac_tag_t               tag_now;
    mac_tag_t               tag_pipe [`FC_RD_LAT];

    assign issue = state == s_issue;
    assign last_beat = word_cnt == last_word;
    assign finish = state == s_done;

    // two words per port per cycle
    always_comb begin
        weight_rd = '0;
        act_rd = '0;
        if (issue) begin
            weight_rd.en = 1'b1;
            weight_rd.addr0 = weight_base + ch_base + word_cnt;
            weight_rd.addr1 = weight_rd.addr0 + 1'b1;
            act_rd.en = 1'b1;
            act_rd.addr0 = act_in_base + word_cnt;
            act_rd.addr1 = act_rd.addr0 + 1'b1;
        end
    end

    assign tag_now = '{valid: issue, last: issue && last_beat, channel: ch_cnt};

    // line the tag up with returning read data
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `FC_RD_LAT; i++) begin
                tag_pipe[i] <= '0;
            end
        end else begin
            tag_pipe[0] <= tag_now;
            for (int i = 1; i < `FC_RD_LAT; i++) begin
                tag_pipe[i] <= tag_pipe[i-1];
            end
        end
    end

    assign tag = tag_pipe[`FC_RD_LAT-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= s_idle;
            ch_cnt <= '0;
            ch_base <= '0;
            word_cnt <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (start) begin
                        state <= s_issue;
                        ch_cnt <= '0;
                        ch_base <= '0;
                        word_cnt <= '0;
                    end
                end
                s_issue: begin
                    if (last_beat) begin
                        state <= s_drain;
                        word_cnt <= '0;
                    end else begin
                        word_cnt <= word_cnt + `FC_ADDR_W'(2);
                    end
                end
                s_drain: begin
                    // channel byte stored, move on
                    if (act_wr.we != 4'b0000) begin
                        if (ch_cnt == last_ch) begin
                            state <= s_done;
                        end else begin
                            state <= s_issue;
                            ch_cnt <= ch_cnt + 1'b1;
                            ch_base <= ch_base + words_per_ch;
                        end
                    end
                end
                s_done: begin
                    state <= s_idle;
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

endmodule

// File: source/fc_layer_pkg.sv
`include "fc_layer_defines.svh"

package fc_layer_pkg;

    // dual-port read, addr1 is always addr0 + 1
    typedef struct packed {
        logic                  en;
        logic [`FC_ADDR_W-1:0] addr0;
        logic [`FC_ADDR_W-1:0] addr1;
    } rd_req_t;

    // bits [31:0] are word0, lane 0 is its low byte
    typedef logic [7:0][7:0] word_pair_t;

    // travels alongside the datapath
    typedef struct packed {
        logic                   valid;
        logic                   last;
        logic [`FC_CH_BITS-1:0] channel;
    } mac_tag_t;

    typedef logic signed [31:0] psum_t;

    // byte-enabled write on activation port 0
    typedef struct packed {
        logic [3:0]            we;
        logic [`FC_ADDR_W-1:0] addr;
        logic [31:0]           data;
    } act_wr_t;

endpackage

// File: source/fc_layer_defines.svh
`ifndef FC_LAYER_DEFINES_SVH
`define FC_LAYER_DEFINES_SVH

// layer shape, IN_LEN must be a multiple of 8
`define FC_IN_LEN 400
`define FC_OUT_CH 120
`define FC_CH_BITS 8

// sram word addressing
`define FC_ADDR_W 16
`define FC_WEIGHT_BASE 1020
`define FC_ACT_IN_BASE 592
`define FC_ACT_OUT_BASE 692

// lowest result bit after scaling
`define FC_QUANT_SHIFT 16

// cycles from read enable to rdata
`define FC_RD_LAT 1

`endif
